/* list.f */
common/axi_adapter_pkg.sv
logic/write_tracker.sv
axi_adapter/axi_write_engine.sv
axi_adapter/axi_read_engine.sv
axi_adapter/axi_adapter.sv
verification/axi_adapter_props.sv
verification/tb_axi_adapter.sv

/* Makefile */
# Verilator build and run for the AXI adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_adapter
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: simulate clean

# the run passes only if the pass message shows up in the output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_axi_adapter.sv */
/*
 * testbench for the AXI adapter
 * random single and line traffic against a bus-slave memory model
 * with random ready and B delays, checked against a reference memory
 */
`default_nettype none

module tb_axi_adapter;

  import axi_adapter_pkg::*;

  localparam int WORDS     = 4;
  localparam int MEM_WORDS = 256;
  localparam int N_ITER    = 40;
  localparam int MAX_TX    = N_ITER * 8;
  localparam int TIMEOUT   = MAX_TX * 200;

  logic clk_i, rst_ni, req_i, we_i;
  req_type_e type_i;
  logic [31:0] addr_i, be_i;
  logic [255:0] wdata_i, rdata_o;
  logic [1:0] size_i;
  logic [3:0] id_i, id_o, aw_id_o, b_id_i, ar_id_o, r_id_i;
  logic gnt_o, valid_o, critical_word_valid_o, busy_o;
  logic [63:0] critical_word_o, w_data_o, r_data_i;
  logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o;
  logic b_valid_i, b_ready_o, ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
  logic [31:0] aw_addr_o, ar_addr_o;
  logic [7:0] aw_len_o, ar_len_o, w_strb_o;
  logic [2:0] aw_size_o, ar_size_o;

  integer seed = 32'h904f_0ff3;
  int cycle = 0;
  logic [63:0] slave_mem [MEM_WORDS];
  logic [63:0] ref_mem [MEM_WORDS];
  logic [3:0] wr_pending [$];
  logic read_active = 1'b0;
  int cw_count;
  logic [63:0] cw_data;

  axi_adapter i_axi_adapter (.*);

  bind axi_adapter axi_adapter_props #(
    .LINE_WIDTH     (LINE_WIDTH),
    .AXI_DATA_WIDTH (AXI_DATA_WIDTH)
  ) i_axi_adapter_props (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_i  (aw_addr_o),
    .aw_len_i   (aw_len_o),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_data_i   (w_data_o),
    .w_last_i   (w_last_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_i  (ar_addr_o),
    .b_valid_i  (b_valid_i),
    .b_ready_i  (b_ready_o),
    .gnt_i      (gnt_o),
    .busy_i     (busy_o)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [63:0] fill_word(int i);
    return {32'(i) * 32'h0101_0101 ^ 32'ha5a5_0000, ~(32'(i) + 32'h1000)};
  endfunction

  function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                              logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic coin();
    return ($random(seed) % 4) != 0;
  endfunction

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(string name, logic [255:0] expected, logic [255:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic report_error(string msg);
    $display("Error: %s", msg);
    stop_run();
  endtask

  // ----------------------------------------
  // clock and timeout
  // ----------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (cycle > TIMEOUT) report_error("timeout, the DUT stopped responding");
  end

  // ----------------------------------------
  // bus slave memory model
  // ----------------------------------------
  logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic [31:0] aw_addr_s, ar_addr_s;
  logic [3:0] aw_id_s, ar_id_s;
  logic [7:0] ar_len_s, w_strb_s;
  logic [63:0] w_data_s;
  logic w_last_s;
  logic aw_got = 1'b0, wlast_got = 1'b0, rd_active = 1'b0;
  int aw_word, wcnt = 0, rd_base, rd_len, rd_beat;
  logic [63:0] wbuf_data [WORDS];
  logic [7:0] wbuf_strb [WORDS];
  logic [3:0] b_id_q [$];
  int b_due_q [$];

  always begin
    @(negedge clk_i);
    aw_fire = aw_valid_o && aw_ready_i;
    w_fire  = w_valid_o && w_ready_i;
    b_fire  = b_valid_i && b_ready_o;
    ar_fire = ar_valid_o && ar_ready_i;
    r_fire  = r_valid_i && r_ready_o;
    aw_addr_s = aw_addr_o;
    aw_id_s   = aw_id_o;
    ar_addr_s = ar_addr_o;
    ar_id_s   = ar_id_o;
    ar_len_s  = ar_len_o;
    w_data_s  = w_data_o;
    w_strb_s  = w_strb_o;
    w_last_s  = w_last_o;
    // a bus word is 8 bytes, so every beat has size 3
    if (aw_fire) begin
      check_value("aw_len", (type_i == REQ_LINE) ? 8'd3 : 8'd0, aw_len_o);
      check_value("aw_id", id_i, aw_id_o);
      check_value("aw_size", 3'd3, aw_size_o);
    end
    if (ar_fire) begin
      check_value("ar_len", (type_i == REQ_LINE) ? 8'd3 : 8'd0, ar_len_o);
      check_value("ar_addr", (type_i == REQ_LINE) ? {addr_i[31:5], 5'b0} : addr_i,
                  ar_addr_o);
      check_value("ar_size", 3'd3, ar_size_o);
    end
    @(posedge clk_i);
    #1;
    if (aw_fire) begin
      aw_got  = 1'b1;
      aw_word = int'(aw_addr_s[10:3]);
    end
    if (w_fire) begin
      wbuf_data[wcnt] = w_data_s;
      wbuf_strb[wcnt] = w_strb_s;
      wcnt++;
      if (w_last_s) wlast_got = 1'b1;
    end
    // commit once the address and the whole burst are in
    if (aw_got && wlast_got) begin
      for (int k = 0; k < wcnt; k++) begin
        slave_mem[(aw_word + k) % MEM_WORDS] =
          merge_bytes(slave_mem[(aw_word + k) % MEM_WORDS], wbuf_data[k], wbuf_strb[k]);
      end
      b_id_q.push_back(aw_id_s);
      b_due_q.push_back(cycle + ($random(seed) & 15));
      aw_got    = 1'b0;
      wlast_got = 1'b0;
      wcnt      = 0;
    end
    if (b_fire) begin
      b_valid_i = 1'b0;
      void'(b_id_q.pop_front());
      void'(b_due_q.pop_front());
    end
    if (!b_valid_i && b_id_q.size() > 0 && b_due_q[0] <= cycle) begin
      b_valid_i = 1'b1;
      b_id_i    = b_id_q[0];
    end
    if (ar_fire) begin
      rd_active = 1'b1;
      rd_base   = int'(ar_addr_s[10:3]);
      rd_len    = int'(ar_len_s);
      rd_beat   = 0;
      r_id_i    = ar_id_s;
    end
    if (r_fire) begin
      r_valid_i = 1'b0;
      if (rd_beat == rd_len) rd_active = 1'b0;
      rd_beat++;
    end
    if (rd_active && !r_valid_i && coin()) begin
      r_valid_i = 1'b1;
      r_data_i  = slave_mem[(rd_base + rd_beat) % MEM_WORDS];
      r_last_i  = (rd_beat == rd_len);
    end
    aw_ready_i = coin();
    w_ready_i  = coin();
    ar_ready_i = coin();
  end

  // ----------------------------------------
  // response monitor and reference memory
  // ----------------------------------------
  task automatic apply_ref_write();
    int base;
    if (type_i == REQ_SINGLE) begin
      base = int'(addr_i[10:3]);
      ref_mem[base] = merge_bytes(ref_mem[base], wdata_i[63:0], be_i[7:0]);
    end else begin
      base = int'({addr_i[10:5], 2'b00});
      for (int k = 0; k < WORDS; k++) begin
        ref_mem[base + k] = merge_bytes(ref_mem[base + k], wdata_i[k*64 +: 64],
                                        be_i[k*8 +: 8]);
      end
    end
  endtask

  always begin
    @(negedge clk_i);
    if (rst_ni) begin
      if (wr_pending.size() > 0 && !busy_o) report_error("busy_o low with writes outstanding");
      if (valid_o && !read_active) begin
        if (wr_pending.size() == 0) report_error("valid_o with no write outstanding");
        check_value("write id", wr_pending.pop_front(), id_o);
      end
      if (gnt_o && we_i) begin
        wr_pending.push_back(id_i);
        apply_ref_write();
      end
      if (critical_word_valid_o) begin
        cw_count++;
        cw_data = critical_word_o;
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic send_req(logic we, req_type_e kind, logic [31:0] addr,
                          logic [255:0] data, logic [31:0] be, logic [3:0] id);
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = we;
    type_i  = kind;
    addr_i  = addr;
    wdata_i = data;
    be_i    = be;
    id_i    = id;
    do @(negedge clk_i); while (!gnt_o);
    if (!we) read_active = 1'b1;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic write_random(req_type_e kind, logic [31:0] addr, logic [3:0] id);
    logic [255:0] data;
    for (int k = 0; k < 8; k++) data[k*32 +: 32] = $random(seed);
    send_req(1'b1, kind, addr, data, $random(seed), id);
  endtask

  // read and compare against the reference memory
  task automatic read_check(req_type_e kind, logic [31:0] addr, logic [3:0] id);
    int base;
    cw_count = 0;
    send_req(1'b0, kind, addr, '0, '0, id);
    do @(negedge clk_i); while (!valid_o);
    check_value("read id", id, id_o);
    if (kind == REQ_SINGLE) begin
      check_value("single read", ref_mem[addr[10:3]], rdata_o[63:0]);
    end else begin
      base = int'({addr[10:5], 2'b00});
      for (int k = 0; k < WORDS; k++) begin
        check_value("line read", ref_mem[base + k], rdata_o[k*64 +: 64]);
      end
      check_value("critical word count", 1, cw_count);
      check_value("critical word", ref_mem[base + int'(addr[4:3])], cw_data);
    end
    @(posedge clk_i);
    #1;
    read_active = 1'b0;
  endtask

  initial begin
    logic [31:0] r, addr;
    logic [3:0] id;
    int n;
    for (int i = 0; i < MEM_WORDS; i++) begin
      slave_mem[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    type_i = REQ_SINGLE;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    size_i = 2'd3;
    id_i = '0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    b_id_i = '0;
    ar_ready_i = 1'b0;
    r_valid_i = 1'b0;
    r_data_i = '0;
    r_id_i = '0;
    r_last_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int it = 0; it < N_ITER; it++) begin
      r  = $random(seed);
      id = r[11:8];
      case (r[1:0])
        2'd0: begin
          addr = {21'b0, r[23:16], 3'b0};
          write_random(REQ_SINGLE, addr, id);
          read_check(REQ_SINGLE, addr, id + 4'd1);
        end
        2'd1: begin
          addr = {21'b0, r[21:16], 5'b0};
          write_random(REQ_LINE, addr, id);
          read_check(REQ_LINE, addr | {27'b0, r[25:24], 3'b0}, id);
        end
        2'd2: read_check(REQ_LINE, {21'b0, r[23:16], 3'b0}, id);
        default: begin
          // same-ID burst whose B responses pile up in the tracker
          n = 3 + int'(r[4:2] % 4);
          for (int k = 0; k < n; k++) begin
            addr = {21'b0, 8'($random(seed)), 3'b0};
            write_random(REQ_SINGLE, addr, id);
          end
          do @(negedge clk_i); while (busy_o);
          check_value("writes left", 0, wr_pending.size());
          read_check(REQ_SINGLE, addr, id);
        end
      endcase
    end

    do @(negedge clk_i); while (busy_o || wr_pending.size() != 0);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/axi_adapter_props.sv */
/*
 * bus protocol checks for the AXI adapter
 * payload stability, w_last placement, read ordering and reset values
 */
`default_nettype none

module axi_adapter_props #(
  parameter int unsigned LINE_WIDTH     = axi_adapter_pkg::LINE_WIDTH,
  parameter int unsigned AXI_DATA_WIDTH = axi_adapter_pkg::AXI_DATA_WIDTH
) (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      aw_valid_i,
  input logic                      aw_ready_i,
  input logic [31:0]               aw_addr_i,
  input logic [7:0]                aw_len_i,
  input logic                      w_valid_i,
  input logic                      w_ready_i,
  input logic [AXI_DATA_WIDTH-1:0] w_data_i,
  input logic                      w_last_i,
  input logic                      ar_valid_i,
  input logic                      ar_ready_i,
  input logic [31:0]               ar_addr_i,
  input logic                      b_valid_i,
  input logic                      b_ready_i,
  input logic                      gnt_i,
  input logic                      busy_i
);

  localparam logic [7:0] LAST_BEAT = 8'(LINE_WIDTH / AXI_DATA_WIDTH - 1);

  logic [7:0] wbeat_q;
  // writes whose address went out and whose B beat is still owed
  logic [7:0] wr_open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wbeat_q <= '0;
    end else if (w_valid_i && w_ready_i) begin
      wbeat_q <= w_last_i ? 8'd0 : wbeat_q + 8'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_open_q <= '0;
    end else begin
      wr_open_q <= wr_open_q + 8'(aw_valid_i && aw_ready_i) - 8'(b_valid_i && b_ready_i);
    end
  end

  // ----------------------------------------
  // valid holds with its payload until ready
  // ----------------------------------------
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_len_i))
    else $error("aw payload changed before ready");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_last_i))
    else $error("w payload changed before ready");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else $error("ar payload changed before ready");

  w_last_place: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i |-> (w_last_i ? (wbeat_q == 8'd0 || wbeat_q == LAST_BEAT) : wbeat_q < LAST_BEAT))
    else $error("w_last on the wrong beat");

  ar_after_writes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i |-> wr_open_q == 8'd0 && !aw_valid_i && !w_valid_i)
    else $error("ar_valid while writes are in flight");

  reset_values: assert property (@(posedge clk_i)
    !rst_ni |-> !aw_valid_i && !w_valid_i && !ar_valid_i && !gnt_i && !busy_i)
    else $error("outputs active during reset");

endmodule

`default_nettype wire

/* axi_adapter/axi_adapter.sv */
/*
 * AXI adapter top level
 * steers cache requests to the write or read engine and
 * merges their grants and responses back onto the request port
 */
`default_nettype none

module axi_adapter #(
  parameter int unsigned LINE_WIDTH      = axi_adapter_pkg::LINE_WIDTH,
  parameter int unsigned AXI_DATA_WIDTH  = axi_adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned ADDR_WIDTH      = axi_adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH        = axi_adapter_pkg::ID_WIDTH,
  parameter int unsigned MAX_OUTSTANDING = axi_adapter_pkg::MAX_OUTSTANDING
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // request side
  input  logic                           req_i,
  input  axi_adapter_pkg::req_type_e     type_i,
  input  logic                           we_i,
  input  logic [ADDR_WIDTH-1:0]          addr_i,
  input  logic [LINE_WIDTH-1:0]          wdata_i,
  input  logic [LINE_WIDTH/8-1:0]        be_i,
  input  logic [1:0]                     size_i,
  input  logic [ID_WIDTH-1:0]            id_i,
  output logic                           gnt_o,
  output logic                           valid_o,
  output logic [LINE_WIDTH-1:0]          rdata_o,
  output logic [ID_WIDTH-1:0]            id_o,
  output logic [AXI_DATA_WIDTH-1:0]      critical_word_o,
  output logic                           critical_word_valid_o,
  output logic                           busy_o,
  // write address channel
  output logic                           aw_valid_o,
  input  logic                           aw_ready_i,
  output logic [ADDR_WIDTH-1:0]          aw_addr_o,
  output logic [7:0]                     aw_len_o,
  output logic [2:0]                     aw_size_o,
  output logic [ID_WIDTH-1:0]            aw_id_o,
  // write data channel
  output logic                           w_valid_o,
  input  logic                           w_ready_i,
  output logic [AXI_DATA_WIDTH-1:0]      w_data_o,
  output logic [AXI_DATA_WIDTH/8-1:0]    w_strb_o,
  output logic                           w_last_o,
  // write response channel
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  input  logic [ID_WIDTH-1:0]            b_id_i,
  // read address channel
  output logic                           ar_valid_o,
  input  logic                           ar_ready_i,
  output logic [ADDR_WIDTH-1:0]          ar_addr_o,
  output logic [7:0]                     ar_len_o,
  output logic [2:0]                     ar_size_o,
  output logic [ID_WIDTH-1:0]            ar_id_o,
  // read data channel
  input  logic                           r_valid_i,
  output logic                           r_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0]      r_data_i,
  input  logic [ID_WIDTH-1:0]            r_id_i,
  input  logic                           r_last_i
);

  logic                wr_req, rd_req;
  logic                wr_gnt, rd_gnt;
  logic                wr_valid, rd_valid;
  logic [ID_WIDTH-1:0] wr_id, rd_id;
  logic                wr_quiet, wr_idle, rd_idle;

  // writes wait for a finished read, reads wait until all B beats are back
  assign wr_req = req_i & we_i & rd_idle;
  assign rd_req = req_i & ~we_i & wr_quiet;

  // the engines never respond in the same cycle
  assign gnt_o   = wr_gnt | rd_gnt;
  assign valid_o = wr_valid | rd_valid;
  assign id_o    = rd_valid ? rd_id : wr_id;

  assign busy_o = ~wr_idle | ~wr_quiet | ~rd_idle;

  axi_write_engine #(
    .LINE_WIDTH      (LINE_WIDTH),
    .AXI_DATA_WIDTH  (AXI_DATA_WIDTH),
    .ADDR_WIDTH      (ADDR_WIDTH),
    .ID_WIDTH        (ID_WIDTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_axi_write_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_req_i   (wr_req),
    .type_i     (type_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .gnt_o      (wr_gnt),
    .valid_o    (wr_valid),
    .id_o       (wr_id),
    .quiet_o    (wr_quiet),
    .idle_o     (wr_idle),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_id_o    (aw_id_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o),
    .b_id_i     (b_id_i)
  );

  axi_read_engine #(
    .LINE_WIDTH     (LINE_WIDTH),
    .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .ID_WIDTH       (ID_WIDTH)
  ) i_axi_read_engine (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rd_req_i              (rd_req),
    .type_i                (type_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .gnt_o                 (rd_gnt),
    .valid_o               (rd_valid),
    .rdata_o               (rdata_o),
    .id_o                  (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .idle_o                (rd_idle),
    .ar_valid_o            (ar_valid_o),
    .ar_ready_i            (ar_ready_i),
    .ar_addr_o             (ar_addr_o),
    .ar_len_o              (ar_len_o),
    .ar_size_o             (ar_size_o),
    .ar_id_o               (ar_id_o),
    .r_valid_i             (r_valid_i),
    .r_ready_o             (r_ready_o),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i)
  );

endmodule

`default_nettype wire

/* axi_adapter/axi_read_engine.sv */
/*
 * AXI read engine
 * issues AR for single and line reads, assembles the line
 * from the R beats and flags the critical word as it passes
 */
`default_nettype none

module axi_read_engine #(
  parameter int unsigned LINE_WIDTH     = axi_adapter_pkg::LINE_WIDTH,
  parameter int unsigned AXI_DATA_WIDTH = axi_adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned ADDR_WIDTH     = axi_adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH       = axi_adapter_pkg::ID_WIDTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rd_req_i,
  input  axi_adapter_pkg::req_type_e type_i,
  input  logic [ADDR_WIDTH-1:0]      addr_i,
  input  logic [1:0]                 size_i,
  input  logic [ID_WIDTH-1:0]        id_i,
  output logic                       gnt_o,
  output logic                       valid_o,
  output logic [LINE_WIDTH-1:0]      rdata_o,
  output logic [ID_WIDTH-1:0]        id_o,
  output logic [AXI_DATA_WIDTH-1:0]  critical_word_o,
  output logic                       critical_word_valid_o,
  output logic                       idle_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output logic [ADDR_WIDTH-1:0]      ar_addr_o,
  output logic [7:0]                 ar_len_o,
  output logic [2:0]                 ar_size_o,
  output logic [ID_WIDTH-1:0]        ar_id_o,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0]  r_data_i,
  input  logic [ID_WIDTH-1:0]        r_id_i,
  input  logic                       r_last_i
);

  import axi_adapter_pkg::*;

  localparam int unsigned WORDS       = LINE_WIDTH / AXI_DATA_WIDTH;
  localparam int unsigned CNT_W       = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam int unsigned WORD_OFFSET = $clog2(AXI_DATA_WIDTH / 8);
  localparam int unsigned LINE_OFFSET = $clog2(LINE_WIDTH / 8);

  rd_state_e             state_q, state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      offset_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic [LINE_WIDTH-1:0] line_q;
  logic                  beat;
  logic [CNT_W-1:0]      index;

  assign ar_size_o = {1'b0, size_i};
  assign ar_id_o   = id_i;
  assign ar_len_o  = (type_i == REQ_LINE) ? 8'(WORDS - 1) : 8'd0;

  // line reads start at the line base
  always_comb begin
    ar_addr_o = addr_i;
    if (type_i == REQ_LINE) ar_addr_o[LINE_OFFSET-1:0] = '0;
  end

  assign idle_o     = (state_q == RD_IDLE);
  assign ar_valid_o = idle_o & rd_req_i;
  assign gnt_o      = ar_valid_o & ar_ready_i;

  assign r_ready_o = (state_q == RD_WAIT_R) || (state_q == RD_WAIT_R_LINE);
  assign beat      = r_ready_o & r_valid_i;
  // single reads land in word 0
  assign index     = (state_q == RD_WAIT_R_LINE) ? cnt_q : '0;

  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = beat && (state_q == RD_WAIT_R_LINE) && (cnt_q == offset_q);

  assign valid_o = (state_q == RD_DONE);
  assign id_o    = id_q;
  assign rdata_o = line_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (gnt_o) state_d = (type_i == REQ_LINE) ? RD_WAIT_R_LINE : RD_WAIT_R;
      end
      RD_WAIT_R, RD_WAIT_R_LINE: begin
        if (beat && r_last_i) state_d = RD_DONE;
      end
      RD_DONE: state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (gnt_o) begin
        cnt_q <= '0;
      end else if (beat) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // word offset of the missing word, captured with the address
  always_ff @(posedge clk_i) begin
    if (gnt_o) offset_q <= addr_i[WORD_OFFSET +: CNT_W];
    if (beat) line_q[index*AXI_DATA_WIDTH +: AXI_DATA_WIDTH] <= r_data_i;
    if (beat && r_last_i) id_q <= r_id_i;
  end

endmodule

`default_nettype wire

/* axi_adapter/axi_write_engine.sv */
/*
 * AXI write engine
 * sequences the AW and W channels for single and line writes
 * and either takes the B beat itself or defers it to the tracker
 */
`default_nettype none

module axi_write_engine #(
  parameter int unsigned LINE_WIDTH      = axi_adapter_pkg::LINE_WIDTH,
  parameter int unsigned AXI_DATA_WIDTH  = axi_adapter_pkg::AXI_DATA_WIDTH,
  parameter int unsigned ADDR_WIDTH      = axi_adapter_pkg::ADDR_WIDTH,
  parameter int unsigned ID_WIDTH        = axi_adapter_pkg::ID_WIDTH,
  parameter int unsigned MAX_OUTSTANDING = axi_adapter_pkg::MAX_OUTSTANDING
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wr_req_i,
  input  axi_adapter_pkg::req_type_e  type_i,
  input  logic [ADDR_WIDTH-1:0]       addr_i,
  input  logic [LINE_WIDTH-1:0]       wdata_i,
  input  logic [LINE_WIDTH/8-1:0]     be_i,
  input  logic [1:0]                  size_i,
  input  logic [ID_WIDTH-1:0]         id_i,
  output logic                        gnt_o,
  output logic                        valid_o,
  output logic [ID_WIDTH-1:0]         id_o,
  output logic                        quiet_o,
  output logic                        idle_o,
  output logic                        aw_valid_o,
  input  logic                        aw_ready_i,
  output logic [ADDR_WIDTH-1:0]       aw_addr_o,
  output logic [7:0]                  aw_len_o,
  output logic [2:0]                  aw_size_o,
  output logic [ID_WIDTH-1:0]         aw_id_o,
  output logic                        w_valid_o,
  input  logic                        w_ready_i,
  output logic [AXI_DATA_WIDTH-1:0]   w_data_o,
  output logic [AXI_DATA_WIDTH/8-1:0] w_strb_o,
  output logic                        w_last_o,
  input  logic                        b_valid_i,
  output logic                        b_ready_o,
  input  logic [ID_WIDTH-1:0]         b_id_i
);

  import axi_adapter_pkg::*;

  localparam int unsigned WORDS  = LINE_WIDTH / AXI_DATA_WIDTH;
  localparam int unsigned STRB_W = AXI_DATA_WIDTH / 8;
  localparam int unsigned CNT_W  = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam logic [7:0]  LINE_LEN = 8'(WORDS - 1);

  wr_state_e             state_q, state_d;
  logic [CNT_W-1:0]      cnt_q, cnt_d;
  logic [ID_WIDTH-1:0]   id_q;
  logic                  defer, can_issue, any_outstanding, full;
  logic                  own_b_ready, trk_b_ready, retire;

  // fixed request fields are held stable until the grant
  assign aw_addr_o = addr_i;
  assign aw_size_o = {1'b0, size_i};
  assign aw_id_o   = id_i;

  // beat counter picks the word and its strobes
  assign w_data_o = wdata_i[cnt_q*AXI_DATA_WIDTH +: AXI_DATA_WIDTH];
  assign w_strb_o = be_i[cnt_q*STRB_W +: STRB_W];
  assign w_last_o = (type_i == REQ_SINGLE) || (cnt_q == CNT_W'(WORDS - 1));

  assign idle_o  = (state_q == WR_IDLE);
  assign quiet_o = idle_o & ~any_outstanding;

  // both the engine and the tracker answer with the B beat's ID
  assign id_o      = b_id_i;
  assign valid_o   = own_b_ready | retire;
  assign b_ready_o = own_b_ready | trk_b_ready;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    aw_valid_o  = 1'b0;
    aw_len_o    = '0;
    w_valid_o   = 1'b0;
    gnt_o       = 1'b0;
    own_b_ready = 1'b0;
    defer       = 1'b0;

    case (state_q)
      // aw and w both still pending
      WR_IDLE, WR_WAIT_W_AW: begin
        if (state_q == WR_WAIT_W_AW || (wr_req_i && can_issue)) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          aw_len_o   = (type_i == REQ_LINE) ? LINE_LEN : 8'd0;
          if (aw_ready_i && w_ready_i && w_last_o) begin
            gnt_o   = 1'b1;
            state_d = WR_WAIT_B;
          end else if (aw_ready_i) begin
            state_d = WR_WAIT_W;
            if (w_ready_i) cnt_d = cnt_q + 1'b1;
          end else if (w_ready_i && w_last_o) begin
            state_d = (type_i == REQ_LINE) ? WR_WAIT_AW_LINE : WR_WAIT_AW;
          end else begin
            state_d = WR_WAIT_W_AW;
            if (w_ready_i) cnt_d = cnt_q + 1'b1;
          end
        end
      end

      WR_WAIT_W: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (w_last_o) begin
            gnt_o   = 1'b1;
            state_d = WR_WAIT_B;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      // all data sent while the address is still owed
      WR_WAIT_AW, WR_WAIT_AW_LINE: begin
        aw_valid_o = 1'b1;
        aw_len_o   = (state_q == WR_WAIT_AW_LINE) ? LINE_LEN : 8'd0;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = WR_WAIT_B;
        end
      end

      WR_WAIT_B: begin
        cnt_d = '0;
        if (b_valid_i && !any_outstanding) begin
          own_b_ready = 1'b1;
          state_d     = WR_IDLE;
        end else if (!full) begin
          // let the tracker collect this response later
          defer   = 1'b1;
          state_d = WR_IDLE;
        end
      end

      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WR_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ID of the write in flight is handed to the tracker on deferral
  always_ff @(posedge clk_i) begin
    if (gnt_o) id_q <= id_i;
  end

  write_tracker #(
    .ID_WIDTH        (ID_WIDTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_write_tracker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .defer_i           (defer),
    .issue_id_i        (id_q),
    .new_id_i          (id_i),
    .can_issue_o       (can_issue),
    .any_outstanding_o (any_outstanding),
    .full_o            (full),
    .b_valid_i         (b_valid_i),
    .b_ready_o         (trk_b_ready),
    .retire_o          (retire)
  );

endmodule

`default_nettype wire

/* logic/write_tracker.sv */
/*
 * outstanding write tracker
 * counts deferred writes, holds their shared ID, decides admission
 * of new writes and retires their B responses
 */
`default_nettype none

module write_tracker #(
  parameter int unsigned ID_WIDTH        = axi_adapter_pkg::ID_WIDTH,
  parameter int unsigned MAX_OUTSTANDING = axi_adapter_pkg::MAX_OUTSTANDING
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                defer_i,
  input  logic [ID_WIDTH-1:0] issue_id_i,
  input  logic [ID_WIDTH-1:0] new_id_i,
  output logic                can_issue_o,
  output logic                any_outstanding_o,
  output logic                full_o,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  output logic                retire_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0]    cnt_q, cnt_d;
  logic [ID_WIDTH-1:0] id_q;

  assign any_outstanding_o = (cnt_q != '0);
  assign full_o            = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  // same ID keeps the B responses in order
  assign can_issue_o = !any_outstanding_o || (new_id_i == id_q);

  // every B beat belongs to a deferred write while any are pending
  assign retire_o  = b_valid_i & any_outstanding_o;
  assign b_ready_o = retire_o;

  // a deferral and a retirement may land in the same cycle
  always_comb begin
    cnt_d = cnt_q;
    if (defer_i) cnt_d = cnt_d + 1'b1;
    if (retire_o) cnt_d = cnt_d - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (defer_i) id_q <= issue_id_i;
  end

endmodule

`default_nettype wire

/* common/axi_adapter_pkg.sv */
/*
 * AXI adapter shared definitions
 * default sizes for the cache line and bus, request kinds and
 * the state encodings of the write and read engines
 */
`default_nettype none

package axi_adapter_pkg;

  // ----------------------------------------
  // default sizes
  // ----------------------------------------
  localparam int unsigned LINE_WIDTH      = 256;
  localparam int unsigned AXI_DATA_WIDTH  = 64;
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned ID_WIDTH        = 4;
  localparam int unsigned MAX_OUTSTANDING = 4;

  // ----------------------------------------
  // request kind
  // ----------------------------------------
  typedef enum logic [0:0] {
    REQ_SINGLE,
    REQ_LINE
  } req_type_e;

  // ----------------------------------------
  // engine states
  // ----------------------------------------
  // write side, aw and w complete in either order
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT_AW,
    WR_WAIT_W,
    WR_WAIT_W_AW,
    WR_WAIT_AW_LINE,
    WR_WAIT_B
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_R,
    RD_WAIT_R_LINE,
    RD_DONE
  } rd_state_e;

endpackage

`default_nettype wire
